// File: hw/mem_pre_pkg.sv
package mem_pre_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int WORD_W     = 32;
    localparam int STRB_W     = 4;
    localparam int INDEX_W    = 12;  // cache index incl. byte offset
    localparam int CL_W       = 5;
    localparam int MATH_SEL_W = 4;
    localparam int TLB_OP_W   = 4;
    localparam int EXC_SEG_W  = 5;

    // one-hot result select positions
    localparam int MATH_ALU = 0;
    localparam int MATH_MUL = 1;
    localparam int MATH_CL  = 2;
    localparam int MATH_MDU = 3;

    // one-hot tlb opcode positions
    localparam int TLB_PROBE         = 0;
    localparam int TLB_WRITE_INDEXED = 1;
    localparam int TLB_WRITE_RANDOM  = 2;
    localparam int TLB_READ          = 3;

    localparam int EXC_SEG_PREMEM = 1;  // this stage in the exception segment vector

    // access size codes on the data bus
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // alu result doubles as the memory address
    typedef union packed {
        logic [WORD_W-1:0] value;
        struct packed {
            logic [WORD_W-INDEX_W-1:0] upper;
            logic [INDEX_W-3:0]        index;
            logic [1:0]                offset;
        } addr;
    } alu_word_u;

endpackage

// File: hw/stage_occupancy.sv
`timescale 1ns/1ps
module stage_occupancy (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             in_valid_i,
    input  logic                             flush_i,
    input  logic                             ok_to_change_i,
    input  logic                             next_allow_in_i,
    input  logic                             exc_occur_i,
    input  logic [mem_pre_pkg::EXC_SEG_W-1:0] exc_seg_i,
    input  logic                             mem_has_risk_i,
    input  logic                             index_ok_i,
    input  logic                             mem_req_q_i,
    input  logic                             tlb_inst_q_i,
    output logic                             allow_in_o,
    output logic                             out_valid_o,
    output logic                             update_o,
    output logic                             clear_o
);
    import mem_pre_pkg::*;

    logic occupied_q;
    logic ready;
    logic need_flush;
    logic pre_valid;

    // the held instruction cannot leave while any of these is true
    assign ready = !((mem_req_q_i && mem_has_risk_i) ||
                     (tlb_inst_q_i && mem_has_risk_i) ||
                     (mem_req_q_i && !index_ok_i));

    assign need_flush = exc_occur_i && exc_seg_i[EXC_SEG_PREMEM];
    assign pre_valid  = in_valid_i && !flush_i;

    assign allow_in_o  = ok_to_change_i && next_allow_in_i && (ready || !occupied_q);
    assign out_valid_o = occupied_q && ready && allow_in_o && !need_flush;
    assign update_o    = allow_in_o && pre_valid;
    assign clear_o     = (allow_in_o && !pre_valid) || need_flush;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occupied_q <= 1'b0;
        end else if (clear_o) begin
            occupied_q <= 1'b0;
        end else if (allow_in_o) begin
            occupied_q <= pre_valid;  // bubble or new instruction
        end
    end

endmodule

// File: hw/stage_regs.sv
`timescale 1ns/1ps
module stage_regs (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                update_i,
    input  logic                                clear_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]      alu_res_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]      mul_res_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]      mdu_res_i,
    input  logic [mem_pre_pkg::CL_W-1:0]        cl_res_i,
    input  logic [mem_pre_pkg::MATH_SEL_W-1:0]  math_sel_i,
    input  logic                                mem_req_i,
    input  logic                                mem_wr_i,
    input  logic [mem_pre_pkg::STRB_W-1:0]      mem_strb_i,
    input  logic                                mem_atom_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]      store_data_i,
    input  logic                                has_exc_i,
    input  logic                                exc_risk_i,
    input  logic                                branch_risk_i,
    input  logic                                eret_i,
    input  logic                                tlb_inst_i,
    input  logic [mem_pre_pkg::TLB_OP_W-1:0]    tlb_op_i,
    output mem_pre_pkg::alu_word_u              alu_q_o,
    output logic [mem_pre_pkg::WORD_W-1:0]      mul_q_o,
    output logic [mem_pre_pkg::WORD_W-1:0]      mdu_q_o,
    output logic [mem_pre_pkg::CL_W-1:0]        cl_q_o,
    output logic [mem_pre_pkg::MATH_SEL_W-1:0]  math_sel_q_o,
    output logic                                mem_req_q_o,
    output logic                                mem_wr_q_o,
    output logic [mem_pre_pkg::STRB_W-1:0]      mem_strb_q_o,
    output logic                                mem_atom_q_o,
    output logic [mem_pre_pkg::WORD_W-1:0]      store_data_q_o,
    output logic                                has_exc_q_o,
    output logic                                exc_risk_q_o,
    output logic                                branch_risk_q_o,
    output logic                                eret_q_o,
    output logic                                tlb_inst_q_o,
    output logic [mem_pre_pkg::TLB_OP_W-1:0]    tlb_op_q_o
);

    ////////////////////////////////////////////////////////////
    // execute -> pre-memory pipeline register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_q_o         <= '0;
            mul_q_o         <= '0;
            mdu_q_o         <= '0;
            cl_q_o          <= '0;
            math_sel_q_o    <= '0;
            mem_req_q_o     <= 1'b0;
            mem_wr_q_o      <= 1'b0;
            mem_strb_q_o    <= '0;
            mem_atom_q_o    <= 1'b0;
            store_data_q_o  <= '0;
            has_exc_q_o     <= 1'b0;
            exc_risk_q_o    <= 1'b0;
            branch_risk_q_o <= 1'b0;
            eret_q_o        <= 1'b0;
            tlb_inst_q_o    <= 1'b0;
            tlb_op_q_o      <= '0;
        end else if (clear_i) begin  // bubble, wins over load
            alu_q_o         <= '0;
            mul_q_o         <= '0;
            mdu_q_o         <= '0;
            cl_q_o          <= '0;
            math_sel_q_o    <= '0;
            mem_req_q_o     <= 1'b0;
            mem_wr_q_o      <= 1'b0;
            mem_strb_q_o    <= '0;
            mem_atom_q_o    <= 1'b0;
            store_data_q_o  <= '0;
            has_exc_q_o     <= 1'b0;
            exc_risk_q_o    <= 1'b0;
            branch_risk_q_o <= 1'b0;
            eret_q_o        <= 1'b0;
            tlb_inst_q_o    <= 1'b0;
            tlb_op_q_o      <= '0;
        end else if (update_i) begin
            alu_q_o         <= alu_res_i;
            mul_q_o         <= mul_res_i;
            mdu_q_o         <= mdu_res_i;
            cl_q_o          <= cl_res_i;
            math_sel_q_o    <= math_sel_i;
            mem_req_q_o     <= mem_req_i;
            mem_wr_q_o      <= mem_wr_i;
            mem_strb_q_o    <= mem_strb_i;
            mem_atom_q_o    <= mem_atom_i;
            store_data_q_o  <= store_data_i;
            has_exc_q_o     <= has_exc_i;
            exc_risk_q_o    <= exc_risk_i;
            branch_risk_q_o <= branch_risk_i;
            eret_q_o        <= eret_i;
            tlb_inst_q_o    <= tlb_inst_i;
            tlb_op_q_o      <= tlb_op_i;
        end
    end

endmodule

// File: hw/dcache_request.sv
`timescale 1ns/1ps
module dcache_request (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  mem_pre_pkg::alu_word_u            alu_q_i,
    input  logic                              mem_req_q_i,
    input  logic                              mem_wr_q_i,
    input  logic [mem_pre_pkg::STRB_W-1:0]    mem_strb_q_i,
    input  logic                              mem_atom_q_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]    store_data_q_i,
    input  logic                              has_exc_q_i,
    input  logic                              eret_q_i,
    input  logic                              mem_has_risk_i,
    input  logic                              next_allow_in_i,
    output logic                              data_req_o,
    output logic                              data_wr_o,
    output logic [mem_pre_pkg::INDEX_W-1:0]   data_index_o,
    output logic [1:0]                        data_size_o,
    output logic [mem_pre_pkg::STRB_W-1:0]    data_wstrb_o,
    output logic [mem_pre_pkg::WORD_W-1:0]    data_wdata_o,
    output logic [1:0]                        align_o,
    output logic                              sc_status_o
);
    import mem_pre_pkg::*;

    logic [$clog2(STRB_W+1)-1:0] strb_cnt;
    logic                        is_ll;
    logic                        is_sc;
    logic                        link_q;

    // an excepting access never reaches the bus
    assign data_req_o   = mem_req_q_i && !has_exc_q_i && !mem_has_risk_i && next_allow_in_i;
    assign data_wr_o    = mem_wr_q_i;
    assign data_index_o = {alu_q_i.addr.index, alu_q_i.addr.offset};
    assign data_wstrb_o = mem_strb_q_i;
    assign data_wdata_o = store_data_q_i;
    assign align_o      = alu_q_i.addr.offset;  // low address bits for alignment check

    ////////////////////////////////////////////////////////////
    // access size from the number of enabled bytes
    ////////////////////////////////////////////////////////////
    always_comb begin
        strb_cnt = '0;
        for (int i = 0; i < STRB_W; i++) begin
            strb_cnt = strb_cnt + {{($bits(strb_cnt)-1){1'b0}}, mem_strb_q_i[i]};
        end
        case (strb_cnt)
            1:       data_size_o = SIZE_BYTE;
            2:       data_size_o = SIZE_HALF;
            default: data_size_o = SIZE_WORD;
        endcase
    end

    // load-linked / store-conditional link bit
    assign is_ll = mem_req_q_i && !mem_wr_q_i && mem_atom_q_i;
    assign is_sc = mem_req_q_i && mem_wr_q_i && mem_atom_q_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            link_q <= 1'b0;
        end else if (eret_q_i) begin
            link_q <= 1'b0;  // eret breaks the link
        end else if (is_ll) begin
            link_q <= 1'b1;
        end
    end

    assign sc_status_o = is_sc && link_q;

endmodule

// File: hw/result_select.sv
`timescale 1ns/1ps
module result_select (
    input  mem_pre_pkg::alu_word_u               alu_q_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]       mul_q_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]       mdu_q_i,
    input  logic [mem_pre_pkg::CL_W-1:0]         cl_q_i,
    input  logic [mem_pre_pkg::MATH_SEL_W-1:0]   math_sel_q_i,
    input  logic                                 sc_status_i,
    output logic [mem_pre_pkg::WORD_W-1:0]       prelim_res_o
);
    import mem_pre_pkg::*;

    logic [WORD_W-1:0] cl_ext;
    logic [WORD_W-1:0] sc_ext;

    assign cl_ext = {{(WORD_W-CL_W){1'b0}}, cl_q_i};
    assign sc_ext = {{(WORD_W-1){1'b0}}, sc_status_i};  // sc result lands in bit 0

    // one-hot and-or mux
    assign prelim_res_o = ({WORD_W{math_sel_q_i[MATH_ALU]}} & alu_q_i.value) |
                          ({WORD_W{math_sel_q_i[MATH_MUL]}} & mul_q_i)       |
                          ({WORD_W{math_sel_q_i[MATH_CL]}}  & cl_ext)        |
                          ({WORD_W{math_sel_q_i[MATH_MDU]}} & mdu_q_i)       |
                          sc_ext;

endmodule

// File: hw/tlb_command.sv
`timescale 1ns/1ps
module tlb_command (
    input  logic                              tlb_inst_q_i,
    input  logic [mem_pre_pkg::TLB_OP_W-1:0]  tlb_op_q_i,
    input  logic                              mem_req_q_i,
    input  logic                              exc_risk_q_i,
    input  logic                              mem_has_risk_i,
    output logic                              tlb_probe_o,
    output logic                              tlb_read_o,
    output logic                              tlb_write_idx_o,
    output logic                              tlb_write_rnd_o,
    output logic                              map_o
);
    import mem_pre_pkg::*;

    logic no_risk;
    logic tlb_go;

    // tlb state is only touched once nothing ahead can still fault
    assign no_risk = !exc_risk_q_i && !mem_has_risk_i;
    assign tlb_go  = tlb_inst_q_i && no_risk;

    assign tlb_probe_o     = tlb_go && tlb_op_q_i[TLB_PROBE];
    assign tlb_read_o      = tlb_go && tlb_op_q_i[TLB_READ];
    assign tlb_write_idx_o = tlb_go && tlb_op_q_i[TLB_WRITE_INDEXED];
    assign tlb_write_rnd_o = tlb_go && tlb_op_q_i[TLB_WRITE_RANDOM];
    assign map_o           = mem_req_q_i && no_risk;  // address translation request

endmodule

// File: hw/mem_pre_stage.sv
`timescale 1ns/1ps
module mem_pre_stage (
    input  logic                                clk,
    input  logic                                arst_n_i,
    // pipeline control
    input  logic                                in_valid_i,
    input  logic                                flush_i,
    input  logic                                ok_to_change_i,
    input  logic                                next_allow_in_i,
    input  logic                                exc_occur_i,
    input  logic [mem_pre_pkg::EXC_SEG_W-1:0]   exc_seg_i,
    input  logic                                mem_has_risk_i,
    input  logic                                index_ok_i,
    // execute fields
    input  logic [mem_pre_pkg::WORD_W-1:0]      alu_res_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]      mul_res_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]      mdu_res_i,
    input  logic [mem_pre_pkg::CL_W-1:0]        cl_res_i,
    input  logic [mem_pre_pkg::MATH_SEL_W-1:0]  math_sel_i,
    input  logic                                mem_req_i,
    input  logic                                mem_wr_i,
    input  logic [mem_pre_pkg::STRB_W-1:0]      mem_strb_i,
    input  logic                                mem_atom_i,
    input  logic [mem_pre_pkg::WORD_W-1:0]      store_data_i,
    input  logic                                has_exc_i,
    input  logic                                exc_risk_i,
    input  logic                                branch_risk_i,
    input  logic                                eret_i,
    input  logic                                tlb_inst_i,
    input  logic [mem_pre_pkg::TLB_OP_W-1:0]    tlb_op_i,
    // outputs
    output logic                                allow_in_o,
    output logic                                out_valid_o,
    output logic                                data_req_o,
    output logic                                data_wr_o,
    output logic [mem_pre_pkg::INDEX_W-1:0]     data_index_o,
    output logic [1:0]                          data_size_o,
    output logic [mem_pre_pkg::STRB_W-1:0]      data_wstrb_o,
    output logic [mem_pre_pkg::WORD_W-1:0]      data_wdata_o,
    output logic [1:0]                          align_o,
    output logic [mem_pre_pkg::WORD_W-1:0]      prelim_res_o,
    output logic                                tlb_probe_o,
    output logic                                tlb_read_o,
    output logic                                tlb_write_idx_o,
    output logic                                tlb_write_rnd_o,
    output logic                                map_o,
    output logic [mem_pre_pkg::WORD_W-1:0]      vaddr_o,
    output logic                                has_risk_o,
    output logic                                exc_risk_o
);
    import mem_pre_pkg::*;

    logic                  update;
    logic                  clear;
    alu_word_u             alu_q;
    logic [WORD_W-1:0]     mul_q;
    logic [WORD_W-1:0]     mdu_q;
    logic [CL_W-1:0]       cl_q;
    logic [MATH_SEL_W-1:0] math_sel_q;
    logic                  mem_req_q;
    logic                  mem_wr_q;
    logic [STRB_W-1:0]     mem_strb_q;
    logic                  mem_atom_q;
    logic [WORD_W-1:0]     store_data_q;
    logic                  has_exc_q;
    logic                  exc_risk_q;
    logic                  branch_risk_q;
    logic                  eret_q;
    logic                  tlb_inst_q;
    logic [TLB_OP_W-1:0]   tlb_op_q;
    logic                  sc_status;

    stage_occupancy u_occ (
        .clk, .arst_n_i, .in_valid_i, .flush_i, .ok_to_change_i, .next_allow_in_i,
        .exc_occur_i, .exc_seg_i, .mem_has_risk_i, .index_ok_i,
        .mem_req_q_i (mem_req_q), .tlb_inst_q_i (tlb_inst_q),
        .allow_in_o, .out_valid_o, .update_o (update), .clear_o (clear)
    );

    stage_regs u_regs (
        .clk, .arst_n_i, .update_i (update), .clear_i (clear),
        .alu_res_i, .mul_res_i, .mdu_res_i, .cl_res_i, .math_sel_i,
        .mem_req_i, .mem_wr_i, .mem_strb_i, .mem_atom_i, .store_data_i,
        .has_exc_i, .exc_risk_i, .branch_risk_i, .eret_i, .tlb_inst_i, .tlb_op_i,
        .alu_q_o (alu_q), .mul_q_o (mul_q), .mdu_q_o (mdu_q), .cl_q_o (cl_q),
        .math_sel_q_o (math_sel_q), .mem_req_q_o (mem_req_q), .mem_wr_q_o (mem_wr_q),
        .mem_strb_q_o (mem_strb_q), .mem_atom_q_o (mem_atom_q),
        .store_data_q_o (store_data_q), .has_exc_q_o (has_exc_q),
        .exc_risk_q_o (exc_risk_q), .branch_risk_q_o (branch_risk_q),
        .eret_q_o (eret_q), .tlb_inst_q_o (tlb_inst_q), .tlb_op_q_o (tlb_op_q)
    );

    dcache_request u_dcache (
        .clk, .arst_n_i, .alu_q_i (alu_q), .mem_req_q_i (mem_req_q),
        .mem_wr_q_i (mem_wr_q), .mem_strb_q_i (mem_strb_q), .mem_atom_q_i (mem_atom_q),
        .store_data_q_i (store_data_q), .has_exc_q_i (has_exc_q), .eret_q_i (eret_q),
        .mem_has_risk_i, .next_allow_in_i,
        .data_req_o, .data_wr_o, .data_index_o, .data_size_o, .data_wstrb_o,
        .data_wdata_o, .align_o, .sc_status_o (sc_status)
    );

    result_select u_res (
        .alu_q_i (alu_q), .mul_q_i (mul_q), .mdu_q_i (mdu_q), .cl_q_i (cl_q),
        .math_sel_q_i (math_sel_q), .sc_status_i (sc_status), .prelim_res_o
    );

    tlb_command u_tlb (
        .tlb_inst_q_i (tlb_inst_q), .tlb_op_q_i (tlb_op_q), .mem_req_q_i (mem_req_q),
        .exc_risk_q_i (exc_risk_q), .mem_has_risk_i,
        .tlb_probe_o, .tlb_read_o, .tlb_write_idx_o, .tlb_write_rnd_o, .map_o
    );

    assign vaddr_o    = alu_q.value;
    assign has_risk_o = exc_risk_q || branch_risk_q || mem_has_risk_i;  // stalls the front
    assign exc_risk_o = has_exc_q || exc_risk_q;

endmodule

// File: tests/tb_mem_pre_stage.sv
`timescale 1ns/1ps
module tb_mem_pre_stage;
    import mem_pre_pkg::*;

    localparam int CACHE_RUNS = 16;
    localparam int TEST_COUNT = 40;  // rough count of issued instructions

    logic                  clk;
    logic                  arst_n_i;
    logic                  in_valid_i, flush_i, ok_to_change_i, next_allow_in_i;
    logic                  exc_occur_i, mem_has_risk_i, index_ok_i;
    logic [EXC_SEG_W-1:0]  exc_seg_i;
    logic [WORD_W-1:0]     alu_res_i, mul_res_i, mdu_res_i, store_data_i;
    logic [CL_W-1:0]       cl_res_i;
    logic [MATH_SEL_W-1:0] math_sel_i;
    logic                  mem_req_i, mem_wr_i, mem_atom_i, has_exc_i;
    logic [STRB_W-1:0]     mem_strb_i;
    logic                  exc_risk_i, branch_risk_i, eret_i, tlb_inst_i;
    logic [TLB_OP_W-1:0]   tlb_op_i;
    logic                  allow_in_o, out_valid_o, data_req_o, data_wr_o;
    logic [INDEX_W-1:0]    data_index_o;
    logic [1:0]            data_size_o, align_o;
    logic [STRB_W-1:0]     data_wstrb_o;
    logic [WORD_W-1:0]     data_wdata_o, prelim_res_o, vaddr_o;
    logic                  tlb_probe_o, tlb_read_o, tlb_write_idx_o, tlb_write_rnd_o;
    logic                  map_o, has_risk_o, exc_risk_o;
    logic [31:0]           lcg_state;

    mem_pre_stage dut_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected size code from the number of enabled bytes
    function automatic logic [1:0] size_for_strobes(input logic [STRB_W-1:0] strb);
        int ones;
        ones = 0;
        for (int i = 0; i < STRB_W; i++) begin
            ones = ones + int'(strb[i]);
        end
        if (ones == 1) begin
            return SIZE_BYTE;
        end else if (ones == 2) begin
            return SIZE_HALF;
        end
        return SIZE_WORD;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("Something failed");
            $fatal(1, "value check");
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle_fields();
        {alu_res_i, mul_res_i, mdu_res_i, store_data_i} = '0;
        {cl_res_i, math_sel_i, mem_strb_i, tlb_op_i} = '0;
        {mem_req_i, mem_wr_i, mem_atom_i, has_exc_i} = '0;
        {exc_risk_i, branch_risk_i, eret_i, tlb_inst_i} = '0;
    endtask

    // hand one instruction over and stop at the middle of the next cycle
    task automatic transfer();
        in_valid_i = 1'b1;
        @(negedge clk);
        while (!allow_in_o) @(negedge clk);
        @(posedge clk);
        #0.5;
        in_valid_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic issue_mem(input logic wr, input logic atom);
        tick();
        idle_fields();
        mem_req_i  = 1'b1;
        mem_wr_i   = wr;
        mem_atom_i = atom;
        mem_strb_i = 4'hf;
        transfer();
    endtask

    task automatic issue_tlb(input logic [TLB_OP_W-1:0] op, input logic erisk,
                             input logic mrisk, input logic brisk);
        tick();
        idle_fields();
        tlb_inst_i     = 1'b1;
        tlb_op_i       = op;
        exc_risk_i     = erisk;
        branch_risk_i  = brisk;
        mem_has_risk_i = mrisk;
        transfer();
        check_value("tlb_probe_o", tlb_probe_o, op[TLB_PROBE] & !erisk & !mrisk);
        check_value("tlb_read_o", tlb_read_o, op[TLB_READ] & !erisk & !mrisk);
        check_value("tlb_write_idx_o", tlb_write_idx_o,
                    op[TLB_WRITE_INDEXED] & !erisk & !mrisk);
        check_value("tlb_write_rnd_o", tlb_write_rnd_o,
                    op[TLB_WRITE_RANDOM] & !erisk & !mrisk);
        check_value("has_risk_o", has_risk_o, erisk | mrisk | brisk);
        check_value("exc_risk_o", exc_risk_o, erisk);
        tick();
        mem_has_risk_i = 1'b0;  // let a stalled tlb op drain
    endtask

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        repeat (TEST_COUNT * 20) @(posedge clk);
        $display("timeout: the tests did not finish in time");
        $display("Something failed");
        $fatal(1, "watchdog");
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        logic [WORD_W-1:0] exp_words [MATH_SEL_W];
        lcg_state       = 32'd93;
        arst_n_i        = 1'b0;
        in_valid_i      = 1'b0;
        flush_i         = 1'b0;
        ok_to_change_i  = 1'b1;
        next_allow_in_i = 1'b1;
        exc_occur_i     = 1'b0;
        exc_seg_i       = '0;
        mem_has_risk_i  = 1'b0;
        index_ok_i      = 1'b1;
        idle_fields();
        repeat (2) @(posedge clk);
        #0.5;
        arst_n_i = 1'b1;
        @(negedge clk);
        check_value("out_valid_o", out_valid_o, 0);
        check_value("data_req_o", data_req_o, 0);
        check_value("map_o", map_o, 0);
        check_value("tlb_probe_o", tlb_probe_o, 0);
        check_value("tlb_read_o", tlb_read_o, 0);
        check_value("tlb_write_idx_o", tlb_write_idx_o, 0);
        check_value("tlb_write_rnd_o", tlb_write_rnd_o, 0);
        check_value("allow_in_o", allow_in_o, 1);

        // cache request fields with random strobes
        for (int n = 0; n < CACHE_RUNS; n++) begin
            tick();
            idle_fields();
            alu_res_i    = rand_word();
            store_data_i = rand_word();
            mem_strb_i   = rand_word() >> 28;
            mem_req_i    = 1'b1;
            mem_wr_i     = n[0];
            transfer();
            check_value("data_req_o", data_req_o, 1);
            check_value("data_wr_o", data_wr_o, mem_wr_i);
            check_value("data_wstrb_o", data_wstrb_o, mem_strb_i);
            check_value("data_wdata_o", data_wdata_o, store_data_i);
            check_value("data_index_o", data_index_o, alu_res_i[INDEX_W-1:0]);
            check_value("data_size_o", data_size_o, size_for_strobes(mem_strb_i));
            check_value("align_o", align_o, alu_res_i[1:0]);
            check_value("vaddr_o", vaddr_o, alu_res_i);
            check_value("map_o", map_o, 1);
            check_value("out_valid_o", out_valid_o, 1);
        end

        // memory risk holds the access in place
        tick();
        idle_fields();
        mem_req_i      = 1'b1;
        mem_has_risk_i = 1'b1;
        transfer();
        check_value("data_req_o", data_req_o, 0);
        check_value("map_o", map_o, 0);
        check_value("allow_in_o", allow_in_o, 0);
        check_value("out_valid_o", out_valid_o, 0);
        tick();
        mem_has_risk_i = 1'b0;
        @(negedge clk);
        check_value("map_o", map_o, 1);
        check_value("out_valid_o", out_valid_o, 1);

        // an excepting access stays off the bus
        tick();
        idle_fields();
        mem_req_i = 1'b1;
        has_exc_i = 1'b1;
        transfer();
        check_value("data_req_o", data_req_o, 0);
        check_value("exc_risk_o", exc_risk_o, 1);
        check_value("out_valid_o", out_valid_o, 1);

        // ll then sc succeeds, an eret in between breaks the link
        issue_mem(1'b0, 1'b1);
        issue_mem(1'b1, 1'b1);
        check_value("prelim_res_o", prelim_res_o, 1);
        issue_mem(1'b0, 1'b1);
        tick();
        idle_fields();
        eret_i = 1'b1;
        transfer();
        issue_mem(1'b1, 1'b1);
        check_value("prelim_res_o", prelim_res_o, 0);

        // one-hot result select, two rounds
        for (int n = 0; n < 2 * MATH_SEL_W; n++) begin
            tick();
            idle_fields();
            alu_res_i  = rand_word();
            mul_res_i  = rand_word();
            mdu_res_i  = rand_word();
            cl_res_i   = rand_word() >> 27;
            math_sel_i = 4'b0001 << (n % MATH_SEL_W);
            exp_words[MATH_ALU] = alu_res_i;
            exp_words[MATH_MUL] = mul_res_i;
            exp_words[MATH_CL]  = {27'd0, cl_res_i};
            exp_words[MATH_MDU] = mdu_res_i;
            transfer();
            check_value("prelim_res_o", prelim_res_o, exp_words[n % MATH_SEL_W]);
        end

        // tlb strobes and their risk gating
        for (int b = 0; b < TLB_OP_W; b++) begin
            issue_tlb(4'b0001 << b, 1'b0, 1'b0, 1'b0);
        end
        issue_tlb(4'b0001 << TLB_PROBE, 1'b1, 1'b0, 1'b0);
        issue_tlb(4'b0001 << TLB_READ, 1'b0, 1'b1, 1'b0);
        issue_tlb(4'b0001 << TLB_PROBE, 1'b0, 1'b0, 1'b1);

        // exception flush of this stage while a new access is offered
        tick();
        idle_fields();
        mem_req_i  = 1'b1;
        mem_strb_i = 4'h1;
        in_valid_i = 1'b1;
        @(negedge clk);
        while (!allow_in_o) @(negedge clk);
        tick();
        exc_occur_i = 1'b1;
        exc_seg_i   = 5'b00010;
        @(negedge clk);
        check_value("out_valid_o", out_valid_o, 0);
        tick();
        in_valid_i  = 1'b0;
        exc_occur_i = 1'b0;
        exc_seg_i   = '0;
        @(negedge clk);
        check_value("out_valid_o", out_valid_o, 0);
        check_value("data_req_o", data_req_o, 0);
        check_value("allow_in_o", allow_in_o, 1);
        issue_mem(1'b0, 1'b0);
        check_value("out_valid_o", out_valid_o, 1);

        $display("Everything OK");
        $finish;
    end

endmodule

// File: mem_pre_stage.f
hw/mem_pre_pkg.sv
hw/stage_occupancy.sv
hw/stage_regs.sv
hw/dcache_request.sv
hw/result_select.sv
hw/tlb_command.sv
hw/mem_pre_stage.sv
tests/tb_mem_pre_stage.sv

// File: Makefile
TB := tb_mem_pre_stage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f mem_pre_stage.f --top-module $(TB)
	out=$$(./obj_dir/V$(TB)); echo "$$out"; \
		echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps \
		-f mem_pre_stage.f --top-module mem_pre_stage

clean:
	rm -rf obj_dir
